// ==== ex_alu.sv ====
`timescale 1ns/1ns
`include "mips_config.svh"

module ex_alu (
	input  mips_pkg::alu_sel_t  alusel_i,
	input  mips_pkg::alu_op_t   aluop_i,
	input  logic [`WORD_W-1:0]  reg1_i,
	input  logic [`WORD_W-1:0]  reg2_i,
	input  logic [`REG_AW-1:0]  wd_i,
	input  logic                wreg_i,
	input  logic [`WORD_W-1:0]  link_addr_i,
	input  mips_pkg::exc_code_t exc_code_i,
	output logic [`REG_AW-1:0]  wd_o,
	output logic                wreg_o,
	output logic [`WORD_W-1:0]  wdata_o,
	output mips_pkg::exc_code_t exc_code_o
);

	logic [`WORD_W-1:0] logic_res;
	logic [`WORD_W-1:0] shift_res;
	logic [`WORD_W-1:0] arith_res;
	logic [`WORD_W-1:0] sum;
	logic [`WORD_W-1:0] diff;
	logic               lt;
	logic               ov;

	assign sum  = reg1_i + reg2_i;
	assign diff = reg1_i - reg2_i;
	assign lt   = $signed(reg1_i) < $signed(reg2_i);

	// Same-sign operands with a result of the other sign
	assign ov = (reg1_i[`WORD_W-1] == reg2_i[`WORD_W-1]) &&
		(sum[`WORD_W-1] != reg1_i[`WORD_W-1]);

	always_comb begin
		case (aluop_i)
			mips_pkg::AND: logic_res = reg1_i & reg2_i;
			mips_pkg::OR:  logic_res = reg1_i | reg2_i;
			mips_pkg::XOR: logic_res = reg1_i ^ reg2_i;
			mips_pkg::LUI: logic_res = {reg2_i[15:0], 16'b0};
			default:       logic_res = '0;
		endcase
	end

	// Shift amount in reg1 and value in reg2
	assign shift_res = (aluop_i == mips_pkg::SRL) ? (reg2_i >> reg1_i[4:0]) :
		(reg2_i << reg1_i[4:0]);

	always_comb begin
		case (aluop_i)
			mips_pkg::SUBU: arith_res = diff;
			mips_pkg::SLT:  arith_res = {{(`WORD_W-1){1'b0}}, lt};
			default:        arith_res = sum;
		endcase
	end

	////////////////////
	// Result select
	////////////////////

	always_comb begin
		case (alusel_i)
			mips_pkg::LOGIC: wdata_o = logic_res;
			mips_pkg::SHIFT: wdata_o = shift_res;
			mips_pkg::ARITH: wdata_o = arith_res;
			mips_pkg::LOAD:  wdata_o = sum;
			mips_pkg::JUMP:  wdata_o = link_addr_i;
			default:         wdata_o = '0;
		endcase
	end

	assign wd_o = wd_i;

	always_comb begin
		exc_code_o = exc_code_i;
		wreg_o     = wreg_i;
		if (exc_code_i != mips_pkg::EC_NONE) begin
			wreg_o = 1'b0;
		end else if (aluop_i == mips_pkg::ADD && ov) begin
			// Trapping add never writes its destination
			exc_code_o = mips_pkg::EC_OV;
			wreg_o     = 1'b0;
		end
	end

endmodule

// ==== ex_core_assert.sv ====
`timescale 1ns/1ns
`include "mips_config.svh"

module ex_core_assert (
	input logic                clk,
	input logic                rst,
	input logic [`STALL_W-1:0] stall_o,
	input logic                flush_i,
	input logic                mem_stallreq_i,
	input logic                ex_wreg_o,
	input mips_pkg::exc_code_t ex_exc_code_o,
	input logic [`WORD_W-1:0]  ex_wdata_o
);

	// Decode stall freezes fetch as well
	stall_id_freezes_fetch: assert property (@(posedge clk) disable iff (!rst)
		stall_o[`ST_ID] |-> (stall_o[`ST_PC] && stall_o[`ST_IF]))
		else $error("ID stall set without PC and IF stall");

	flush_gives_bubble: assert property (@(posedge clk) disable iff (!rst)
		flush_i |=> !ex_wreg_o)
		else $error("ex_wreg_o set in the cycle after a flush");

	exception_blocks_write: assert property (@(posedge clk) disable iff (!rst)
		(ex_exc_code_o != mips_pkg::EC_NONE) |-> !ex_wreg_o)
		else $error("ex_wreg_o set together with an exception code");

	// Result must not move while the EX register holds
	mem_stall_holds_result: assert property (@(posedge clk) disable iff (!rst)
		(mem_stallreq_i && !flush_i) |=> $stable(ex_wdata_o))
		else $error("ex_wdata_o changed under a memory stall");

endmodule

bind ex_core_top ex_core_assert u_ex_core_assert (
	.clk            (clk),
	.rst            (rst),
	.stall_o        (stall_o),
	.flush_i        (flush_i),
	.mem_stallreq_i (mem_stallreq_i),
	.ex_wreg_o      (ex_wreg_o),
	.ex_exc_code_o  (ex_exc_code_o),
	.ex_wdata_o     (ex_wdata_o)
);

// ==== ex_core_input.txt ====
// pc inst reg1 reg2 ctrl(b0 mem_stall b1 flush b2 random b3 bubble) stall wd wreg wdata code dslot
// One row per cycle, expected columns hold after the next rising edge, ffffffff ends the list
00400000 00221821 00000000 00000000 4 00 03 1 00000000 00 0
00400004 00222023 00000000 00000000 4 00 04 1 00000000 00 0
00400008 0022282a 00000000 00000000 4 00 05 1 00000000 00 0
0040000c 00223026 00000000 00000000 4 00 06 1 00000000 00 0
00400010 00223824 f0f0ff00 0ff0f0f0 0 00 07 1 00f0f000 00 0
00400014 00224025 12340000 00005678 0 00 08 1 12345678 00 0
00400018 00024900 deadbeef 000000ff 0 00 09 1 00000ff0 00 0
0040001c 00025202 00000000 80000000 0 00 0a 1 00800000 00 0
00400020 342b00ff 12340f00 00000000 0 00 0b 1 12340fff 00 0
00400024 242cfffe 00000010 00000000 0 00 0c 1 0000000e 00 0
00400028 3c0dbeef 00000000 00000000 0 00 0d 1 beef0000 00 0
0040002c 00227020 7fffffff 00000001 0 00 0e 0 80000000 0c 0
00400030 0000000c 00000000 00000000 0 00 00 0 00000000 08 0
00400034 fc000000 00000000 00000000 0 00 00 0 00000000 0a 0
00400038 0c100040 00000000 00000000 0 00 1f 1 00400040 00 0
0040003c 00221821 00000001 00000002 0 00 03 1 00000003 00 1
00400100 8c250008 10000000 00000000 0 00 05 1 10000008 00 0
00400104 00a23021 00000100 00000023 8 07 00 0 00000000 00 0
00400104 00a23021 00000100 00000023 0 00 06 1 00000123 00 0
00400108 00224025 0000a000 00000055 0 00 08 1 0000a055 00 0
0040010c 00223026 ffff0000 0f0f0f0f 1 1f 08 1 0000a055 00 0
0040010c 00223026 ffff0000 0f0f0f0f 1 1f 08 1 0000a055 00 0
0040010c 00223026 ffff0000 0f0f0f0f 1 1f 08 1 0000a055 00 0
0040010c 00223026 ffff0000 0f0f0f0f 0 00 06 1 f0f00f0f 00 0
00400110 242c0005 00000010 00000000 a 00 00 0 00000000 00 0
00400114 242c0005 00000010 00000000 0 00 0c 1 00000015 00 0
ffffffff

// ==== ex_core_top.sv ====
`timescale 1ns/1ns
`include "mips_config.svh"

module ex_core_top (
	input  logic                clk,
	input  logic                rst,
	input  logic [`WORD_W-1:0]  pc_i,
	input  logic [`WORD_W-1:0]  inst_i,
	input  logic [`WORD_W-1:0]  reg1_data_i,
	input  logic [`WORD_W-1:0]  reg2_data_i,
	input  logic                mem_stallreq_i,
	input  logic                flush_i,
	output logic [`REG_AW-1:0]  reg1_addr_o,
	output logic [`REG_AW-1:0]  reg2_addr_o,
	output logic [`STALL_W-1:0] stall_o,
	output mips_pkg::alu_op_t   ex_aluop_o,
	output logic [`REG_AW-1:0]  ex_wd_o,
	output logic                ex_wreg_o,
	output logic [`WORD_W-1:0]  ex_wdata_o,
	output mips_pkg::exc_code_t ex_exc_code_o,
	output logic [`WORD_W-1:0]  ex_epc_o,
	output logic                ex_in_delayslot_o
);

	////////////////////
	// Decode to ID/EX
	////////////////////

	mips_pkg::alu_sel_t  id_alusel;
	mips_pkg::alu_op_t   id_aluop;
	logic [`WORD_W-1:0]  id_reg1;
	logic [`WORD_W-1:0]  id_reg2;
	logic [`REG_AW-1:0]  id_wd;
	logic                id_wreg;
	logic [`WORD_W-1:0]  id_link_addr;
	logic                id_next_in_delayslot;
	logic                id_is_in_delayslot;
	logic [`WORD_W-1:0]  id_inst;
	mips_pkg::exc_code_t id_exc_code;
	logic [`WORD_W-1:0]  id_epc;
	logic                stallreq_id;

	////////////////////
	// ID/EX to ALU
	////////////////////

	mips_pkg::alu_sel_t  ex_alusel;
	logic [`WORD_W-1:0]  ex_reg1;
	logic [`WORD_W-1:0]  ex_reg2;
	logic [`REG_AW-1:0]  ex_wd;
	logic                ex_wreg;
	logic [`WORD_W-1:0]  ex_link_addr;
	mips_pkg::exc_code_t ex_exc_code;
	logic                in_delayslot;

	id_decode u_id_decode (
		.inst_i              (inst_i),
		.pc_i                (pc_i),
		.reg1_data_i         (reg1_data_i),
		.reg2_data_i         (reg2_data_i),
		.in_delayslot_i      (in_delayslot),
		.ex_aluop_i          (ex_aluop_o),
		.ex_wd_i             (ex_wd),
		.reg1_addr_o         (reg1_addr_o),
		.reg2_addr_o         (reg2_addr_o),
		.alusel_o            (id_alusel),
		.aluop_o             (id_aluop),
		.reg1_o              (id_reg1),
		.reg2_o              (id_reg2),
		.wd_o                (id_wd),
		.wreg_o              (id_wreg),
		.link_addr_o         (id_link_addr),
		.next_in_delayslot_o (id_next_in_delayslot),
		.is_in_delayslot_o   (id_is_in_delayslot),
		.inst_o              (id_inst),
		.exc_code_o          (id_exc_code),
		.epc_o               (id_epc),
		.stallreq_o          (stallreq_id)
	);

	pipe_ctrl u_pipe_ctrl (
		.stallreq_id_i  (stallreq_id),
		.stallreq_mem_i (mem_stallreq_i),
		.stall_o        (stall_o)
	);

	// Instruction word is kept for later stages
	id_ex u_id_ex (
		.clk                    (clk),
		.rst                    (rst),
		.stall_i                (stall_o),
		.flush_i                (flush_i),
		.id_alusel_i            (id_alusel),
		.id_aluop_i             (id_aluop),
		.id_reg1_i              (id_reg1),
		.id_reg2_i              (id_reg2),
		.id_wd_i                (id_wd),
		.id_wreg_i              (id_wreg),
		.id_link_addr_i         (id_link_addr),
		.id_inst_i              (id_inst),
		.id_exc_code_i          (id_exc_code),
		.id_epc_i               (id_epc),
		.id_is_in_delayslot_i   (id_is_in_delayslot),
		.id_next_in_delayslot_i (id_next_in_delayslot),
		.ex_alusel_o            (ex_alusel),
		.ex_aluop_o             (ex_aluop_o),
		.ex_reg1_o              (ex_reg1),
		.ex_reg2_o              (ex_reg2),
		.ex_wd_o                (ex_wd),
		.ex_wreg_o              (ex_wreg),
		.ex_link_addr_o         (ex_link_addr),
		.ex_inst_o              (),
		.ex_exc_code_o          (ex_exc_code),
		.ex_epc_o               (ex_epc_o),
		.ex_in_delayslot_o      (ex_in_delayslot_o),
		.is_in_delayslot_o      (in_delayslot)
	);

	ex_alu u_ex_alu (
		.alusel_i    (ex_alusel),
		.aluop_i     (ex_aluop_o),
		.reg1_i      (ex_reg1),
		.reg2_i      (ex_reg2),
		.wd_i        (ex_wd),
		.wreg_i      (ex_wreg),
		.link_addr_i (ex_link_addr),
		.exc_code_i  (ex_exc_code),
		.wd_o        (ex_wd_o),
		.wreg_o      (ex_wreg_o),
		.wdata_o     (ex_wdata_o),
		.exc_code_o  (ex_exc_code_o)
	);

endmodule

// ==== id_decode.sv ====
`timescale 1ns/1ns
`include "mips_config.svh"

module id_decode (
	input  logic [`WORD_W-1:0]  inst_i,
	input  logic [`WORD_W-1:0]  pc_i,
	input  logic [`WORD_W-1:0]  reg1_data_i,
	input  logic [`WORD_W-1:0]  reg2_data_i,
	input  logic                in_delayslot_i,
	input  mips_pkg::alu_op_t   ex_aluop_i,
	input  logic [`REG_AW-1:0]  ex_wd_i,
	output logic [`REG_AW-1:0]  reg1_addr_o,
	output logic [`REG_AW-1:0]  reg2_addr_o,
	output mips_pkg::alu_sel_t  alusel_o,
	output mips_pkg::alu_op_t   aluop_o,
	output logic [`WORD_W-1:0]  reg1_o,
	output logic [`WORD_W-1:0]  reg2_o,
	output logic [`REG_AW-1:0]  wd_o,
	output logic                wreg_o,
	output logic [`WORD_W-1:0]  link_addr_o,
	output logic                next_in_delayslot_o,
	output logic                is_in_delayslot_o,
	output logic [`WORD_W-1:0]  inst_o,
	output mips_pkg::exc_code_t exc_code_o,
	output logic [`WORD_W-1:0]  epc_o,
	output logic                stallreq_o
);

	logic [5:0]         op;
	logic [5:0]         funct;
	logic [`REG_AW-1:0] rs;
	logic [`REG_AW-1:0] rt;
	logic [`REG_AW-1:0] rd;
	logic [4:0]         shamt;
	logic [`WORD_W-1:0] imm;
	logic               reg1_read;
	logic               reg2_read;

	assign op    = inst_i[31:26];
	assign rs    = inst_i[25:21];
	assign rt    = inst_i[20:16];
	assign rd    = inst_i[15:11];
	assign shamt = inst_i[10:6];
	assign funct = inst_i[5:0];

	// Register file is always addressed with rs and rt
	assign reg1_addr_o       = rs;
	assign reg2_addr_o       = rt;
	assign inst_o            = inst_i;
	assign epc_o             = pc_i;
	assign is_in_delayslot_o = in_delayslot_i;

	always_comb begin
		alusel_o            = mips_pkg::NOP;
		aluop_o             = mips_pkg::SLL;
		wd_o                = rd;
		wreg_o              = 1'b0;
		reg1_read           = 1'b0;
		reg2_read           = 1'b0;
		imm                 = '0;
		link_addr_o         = '0;
		next_in_delayslot_o = 1'b0;
		exc_code_o          = mips_pkg::EC_NONE;
		case (op)
			6'b000000: begin
				// Most R-type instructions read both sources
				wreg_o    = 1'b1;
				reg1_read = 1'b1;
				reg2_read = 1'b1;
				case (funct)
					6'b100000: begin
						alusel_o = mips_pkg::ARITH;
						aluop_o  = mips_pkg::ADD;
					end
					6'b100001: begin
						alusel_o = mips_pkg::ARITH;
						aluop_o  = mips_pkg::ADDU;
					end
					6'b100011: begin
						alusel_o = mips_pkg::ARITH;
						aluop_o  = mips_pkg::SUBU;
					end
					6'b101010: begin
						alusel_o = mips_pkg::ARITH;
						aluop_o  = mips_pkg::SLT;
					end
					6'b100100: begin
						alusel_o = mips_pkg::LOGIC;
						aluop_o  = mips_pkg::AND;
					end
					6'b100101: begin
						alusel_o = mips_pkg::LOGIC;
						aluop_o  = mips_pkg::OR;
					end
					6'b100110: begin
						alusel_o = mips_pkg::LOGIC;
						aluop_o  = mips_pkg::XOR;
					end
					6'b000000, 6'b000010: begin
						// Shift amount rides in operand 1 and rt in operand 2
						alusel_o  = mips_pkg::SHIFT;
						aluop_o   = funct[1] ? mips_pkg::SRL : mips_pkg::SLL;
						reg1_read = 1'b0;
						imm       = {{(`WORD_W-5){1'b0}}, shamt};
					end
					6'b001100: begin
						wreg_o     = 1'b0;
						reg1_read  = 1'b0;
						reg2_read  = 1'b0;
						exc_code_o = mips_pkg::EC_SYS;
					end
					default: begin
						wreg_o     = 1'b0;
						reg1_read  = 1'b0;
						reg2_read  = 1'b0;
						exc_code_o = mips_pkg::EC_RI;
					end
				endcase
			end
			6'b001101: begin
				alusel_o  = mips_pkg::LOGIC;
				aluop_o   = mips_pkg::OR;
				wd_o      = rt;
				wreg_o    = 1'b1;
				reg1_read = 1'b1;
				imm       = {{(`WORD_W-16){1'b0}}, inst_i[15:0]};
			end
			6'b001001: begin
				alusel_o  = mips_pkg::ARITH;
				aluop_o   = mips_pkg::ADDU;
				wd_o      = rt;
				wreg_o    = 1'b1;
				reg1_read = 1'b1;
				imm       = {{(`WORD_W-16){inst_i[15]}}, inst_i[15:0]};
			end
			6'b001111: begin
				alusel_o = mips_pkg::LOGIC;
				aluop_o  = mips_pkg::LUI;
				wd_o     = rt;
				wreg_o   = 1'b1;
				imm      = {{(`WORD_W-16){1'b0}}, inst_i[15:0]};
			end
			6'b100011: begin
				// Only the address is formed here
				alusel_o  = mips_pkg::LOAD;
				aluop_o   = mips_pkg::LW;
				wd_o      = rt;
				wreg_o    = 1'b1;
				reg1_read = 1'b1;
				imm       = {{(`WORD_W-16){inst_i[15]}}, inst_i[15:0]};
			end
			6'b000011: begin
				alusel_o            = mips_pkg::JUMP;
				aluop_o             = mips_pkg::JAL;
				wd_o                = {`REG_AW{1'b1}};
				wreg_o              = 1'b1;
				link_addr_o         = pc_i + {{(`WORD_W-4){1'b0}}, 4'd8};
				next_in_delayslot_o = 1'b1;
			end
			default: begin
				exc_code_o = mips_pkg::EC_RI;
			end
		endcase
	end

	// Unread operands carry the immediate instead
	assign reg1_o = reg1_read ? reg1_data_i : imm;
	assign reg2_o = reg2_read ? reg2_data_i : imm;

	// Load in EX writes a register this instruction still needs
	assign stallreq_o = (ex_aluop_i == mips_pkg::LW) && (ex_wd_i != '0) &&
		((reg1_read && (ex_wd_i == rs)) || (reg2_read && (ex_wd_i == rt)));

endmodule

// ==== id_ex.sv ====
`timescale 1ns/1ns
`include "mips_config.svh"

module id_ex (
	input  logic                clk,
	input  logic                rst,
	input  logic [`STALL_W-1:0] stall_i,
	input  logic                flush_i,
	input  mips_pkg::alu_sel_t  id_alusel_i,
	input  mips_pkg::alu_op_t   id_aluop_i,
	input  logic [`WORD_W-1:0]  id_reg1_i,
	input  logic [`WORD_W-1:0]  id_reg2_i,
	input  logic [`REG_AW-1:0]  id_wd_i,
	input  logic                id_wreg_i,
	input  logic [`WORD_W-1:0]  id_link_addr_i,
	input  logic [`WORD_W-1:0]  id_inst_i,
	input  mips_pkg::exc_code_t id_exc_code_i,
	input  logic [`WORD_W-1:0]  id_epc_i,
	input  logic                id_is_in_delayslot_i,
	input  logic                id_next_in_delayslot_i,
	output mips_pkg::alu_sel_t  ex_alusel_o,
	output mips_pkg::alu_op_t   ex_aluop_o,
	output logic [`WORD_W-1:0]  ex_reg1_o,
	output logic [`WORD_W-1:0]  ex_reg2_o,
	output logic [`REG_AW-1:0]  ex_wd_o,
	output logic                ex_wreg_o,
	output logic [`WORD_W-1:0]  ex_link_addr_o,
	output logic [`WORD_W-1:0]  ex_inst_o,
	output mips_pkg::exc_code_t ex_exc_code_o,
	output logic [`WORD_W-1:0]  ex_epc_o,
	output logic                ex_in_delayslot_o,
	output logic                is_in_delayslot_o
);

	logic load_bubble;

	// Flush or ID stalled while EX keeps moving
	assign load_bubble = flush_i || (stall_i[`ST_ID] && !stall_i[`ST_EX]);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ex_alusel_o       <= mips_pkg::NOP;
			ex_aluop_o        <= mips_pkg::SLL;
			ex_reg1_o         <= '0;
			ex_reg2_o         <= '0;
			ex_wd_o           <= '0;
			ex_wreg_o         <= 1'b0;
			ex_link_addr_o    <= '0;
			ex_inst_o         <= '0;
			ex_exc_code_o     <= mips_pkg::EC_NONE;
			ex_epc_o          <= '0;
			ex_in_delayslot_o <= 1'b0;
			is_in_delayslot_o <= 1'b0;
		end else if (load_bubble) begin
			ex_alusel_o       <= mips_pkg::NOP;
			ex_aluop_o        <= mips_pkg::SLL;
			ex_reg1_o         <= '0;
			ex_reg2_o         <= '0;
			ex_wd_o           <= '0;
			ex_wreg_o         <= 1'b0;
			ex_link_addr_o    <= '0;
			ex_inst_o         <= '0;
			ex_exc_code_o     <= mips_pkg::EC_NONE;
			ex_epc_o          <= '0;
			ex_in_delayslot_o <= 1'b0;
			is_in_delayslot_o <= 1'b0;
		end else if (!stall_i[`ST_ID]) begin
			ex_alusel_o       <= id_alusel_i;
			ex_aluop_o        <= id_aluop_i;
			ex_reg1_o         <= id_reg1_i;
			ex_reg2_o         <= id_reg2_i;
			ex_wd_o           <= id_wd_i;
			ex_wreg_o         <= id_wreg_i;
			ex_link_addr_o    <= id_link_addr_i;
			ex_inst_o         <= id_inst_i;
			ex_exc_code_o     <= id_exc_code_i;
			ex_epc_o          <= id_epc_i;
			ex_in_delayslot_o <= id_is_in_delayslot_i;
			// Fed back to decode to tag the instruction after a jump
			is_in_delayslot_o <= id_next_in_delayslot_i;
		end
	end

endmodule

// ==== mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Datapath widths
`define WORD_W  32
`define REG_AW  5

// One stall bit per pipeline stage
`define STALL_W 6

`define ST_PC   0
`define ST_IF   1
`define ST_ID   2
`define ST_EX   3
`define ST_MEM  4
`define ST_WB   5

`endif

// ==== mips_pkg.sv ====
package mips_pkg;

	// Result class picks which ALU unit feeds the write data
	typedef enum logic [2:0] {
		NOP   = 3'b000,
		LOGIC = 3'b001,
		SHIFT = 3'b010,
		ARITH = 3'b100,
		JUMP  = 3'b110,
		LOAD  = 3'b111
	} alu_sel_t;

	// SLL doubles as the bubble value
	typedef enum logic [7:0] {
		SLL  = 8'b0111_1100,
		SRL  = 8'b0000_0010,
		AND  = 8'b0010_0100,
		OR   = 8'b0010_0101,
		XOR  = 8'b0010_0110,
		ADD  = 8'b0010_0000,
		ADDU = 8'b0010_0001,
		SUBU = 8'b0010_0011,
		SLT  = 8'b0010_1010,
		LUI  = 8'b0101_1100,
		LW   = 8'b1110_0011,
		JAL  = 8'b0101_0000
	} alu_op_t;

	////////////////////
	// Exception codes
	////////////////////

	// Nonzero values follow the CP0 Cause.ExcCode numbering
	typedef enum logic [4:0] {
		EC_NONE = 5'h00,
		EC_SYS  = 5'h08,
		EC_RI   = 5'h0a,
		EC_OV   = 5'h0c
	} exc_code_t;

endpackage

// ==== pipe_ctrl.sv ====
`timescale 1ns/1ns
`include "mips_config.svh"

module pipe_ctrl (
	input  logic                stallreq_id_i,
	input  logic                stallreq_mem_i,
	output logic [`STALL_W-1:0] stall_o
);

	always_comb begin
		stall_o = '0;
		if (stallreq_mem_i) begin
			// Freeze everything up to MEM
			stall_o[`ST_PC]  = 1'b1;
			stall_o[`ST_IF]  = 1'b1;
			stall_o[`ST_ID]  = 1'b1;
			stall_o[`ST_EX]  = 1'b1;
			stall_o[`ST_MEM] = 1'b1;
			// Writeback keeps draining
			stall_o[`ST_WB]  = 1'b0;
		end else if (stallreq_id_i) begin
			// Load-use hazard gives EX a bubble
			stall_o[`ST_PC] = 1'b1;
			stall_o[`ST_IF] = 1'b1;
			stall_o[`ST_ID] = 1'b1;
		end
	end

endmodule

// ==== project.f ====
+incdir+.
mips_pkg.sv
id_decode.sv
id_ex.sv
ex_alu.sv
pipe_ctrl.sv
ex_core_top.sv
ex_core_assert.sv
tb_ex_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f project.f --top-module tb_ex_core -o tb_ex_core

./obj_dir/tb_ex_core > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Some tests failed" sim.log; then
	exit 1
fi

// ==== tb_ex_core.sv ====
`timescale 1ns/1ns
`include "mips_config.svh"

module tb_ex_core;

	localparam int COLS          = 11;
	localparam int MAX_ROWS      = 64;
	localparam int STALL_TIMEOUT = 20;

	logic                clk;
	logic                rst;
	logic [`WORD_W-1:0]  pc_i;
	logic [`WORD_W-1:0]  inst_i;
	logic [`WORD_W-1:0]  reg1_data_i;
	logic [`WORD_W-1:0]  reg2_data_i;
	logic                mem_stallreq_i;
	logic                flush_i;
	logic [`REG_AW-1:0]  reg1_addr_o;
	logic [`REG_AW-1:0]  reg2_addr_o;
	logic [`STALL_W-1:0] stall_o;
	mips_pkg::alu_op_t   ex_aluop_o;
	logic [`REG_AW-1:0]  ex_wd_o;
	logic                ex_wreg_o;
	logic [`WORD_W-1:0]  ex_wdata_o;
	mips_pkg::exc_code_t ex_exc_code_o;
	logic [`WORD_W-1:0]  ex_epc_o;
	logic                ex_in_delayslot_o;

	// One row of COLS words per cycle
	logic [31:0]        vec [0:COLS*MAX_ROWS-1];
	integer             seed;
	int                 errors;
	int                 tests;
	int                 failed;
	int                 row;
	int                 base;
	int                 errs_before;
	bit                 done;
	logic [`WORD_W-1:0] exp_wdata;

	ex_core_top dut_i (
		.clk               (clk),
		.rst               (rst),
		.pc_i              (pc_i),
		.inst_i            (inst_i),
		.reg1_data_i       (reg1_data_i),
		.reg2_data_i       (reg2_data_i),
		.mem_stallreq_i    (mem_stallreq_i),
		.flush_i           (flush_i),
		.reg1_addr_o       (reg1_addr_o),
		.reg2_addr_o       (reg2_addr_o),
		.stall_o           (stall_o),
		.ex_aluop_o        (ex_aluop_o),
		.ex_wd_o           (ex_wd_o),
		.ex_wreg_o         (ex_wreg_o),
		.ex_wdata_o        (ex_wdata_o),
		.ex_exc_code_o     (ex_exc_code_o),
		.ex_epc_o          (ex_epc_o),
		.ex_in_delayslot_o (ex_in_delayslot_o)
	);

	always #10 clk = ~clk;

	// Reference results for R-type rows with random operands
	function automatic logic [`WORD_W-1:0] rtype_result(input logic [5:0] funct,
		input logic [`WORD_W-1:0] a, input logic [`WORD_W-1:0] b);
		case (funct)
			6'h21:   return a + b;
			6'h23:   return a - b;
			6'h24:   return a & b;
			6'h25:   return a | b;
			6'h26:   return a ^ b;
			6'h2a:   return {{(`WORD_W-1){1'b0}}, $signed(a) < $signed(b)};
			default: return '0;
		endcase
	endfunction

	////////////////////
	// Compare tasks
	////////////////////

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_code(input string name, input mips_pkg::exc_code_t exp,
		input mips_pkg::exc_code_t act);
		if (act !== exp) begin
			$display("Mismatch at %0t: %s expected %s (%h), got %s (%h)", $time, name,
				exp.name(), exp, act.name(), act);
			errors++;
		end
	endtask

	task automatic check_op(input string name, input mips_pkg::alu_op_t exp,
		input mips_pkg::alu_op_t act);
		if (act !== exp) begin
			$display("Mismatch at %0t: %s expected %s (%h), got %s (%h)", $time, name,
				exp.name(), exp, act.name(), act);
			errors++;
		end
	endtask

	task automatic wait_stall_clear(input string where);
		int cycles;
		cycles = 0;
		while (stall_o != '0 && cycles < STALL_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (stall_o != '0) begin
			$display("Timeout at %0t: stall_o still set %0d cycles after %s", $time,
				cycles, where);
			errors++;
		end
	endtask

	task automatic finish_test(input string label, input int errs_at_start);
		tests++;
		if (errors == errs_at_start) begin
			$display("Test %0d %s: ok", tests, label);
		end else begin
			failed++;
			$display("Test %0d %s: FAILED", tests, label);
		end
	endtask

	task automatic drive_row(input int b);
		pc_i           = vec[b];
		inst_i         = vec[b+1];
		mem_stallreq_i = vec[b+4][0];
		flush_i        = vec[b+4][1];
		if (vec[b+4][2]) begin
			reg1_data_i = $random(seed);
			reg2_data_i = $random(seed);
			exp_wdata   = rtype_result(vec[b+1][5:0], reg1_data_i, reg2_data_i);
		end else begin
			reg1_data_i = vec[b+2];
			reg2_data_i = vec[b+3];
			exp_wdata   = vec[b+8];
		end
	endtask

	task automatic check_row(input int b);
		check_word("ex_wd_o", vec[b+6], 32'(ex_wd_o));
		check_word("ex_wreg_o", vec[b+7], 32'(ex_wreg_o));
		check_word("ex_wdata_o", exp_wdata, ex_wdata_o);
		check_code("ex_exc_code_o", mips_pkg::exc_code_t'(vec[b+9][4:0]), ex_exc_code_o);
		check_word("ex_in_delayslot_o", vec[b+10], 32'(ex_in_delayslot_o));
		// Exceptions carry their own PC
		if (vec[b+9][4:0] != 5'h00) begin
			check_word("ex_epc_o", vec[b], ex_epc_o);
		end
		if (vec[b+4][3]) begin
			check_op("ex_aluop_o", mips_pkg::SLL, ex_aluop_o);
		end
	endtask

	initial begin
		seed           = 32'h2bfd181d;
		errors         = 0;
		tests          = 0;
		failed         = 0;
		clk            = 1'b0;
		rst            = 1'b0;
		pc_i           = '0;
		inst_i         = '0;
		reg1_data_i    = '0;
		reg2_data_i    = '0;
		mem_stallreq_i = 1'b0;
		flush_i        = 1'b0;
		exp_wdata      = '0;
		$readmemh("ex_core_input.txt", vec);

		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;

		// Bubble in EX straight out of reset
		errs_before = errors;
		wait_stall_clear("reset");
		check_word("ex_wreg_o", 32'h0, 32'(ex_wreg_o));
		check_code("ex_exc_code_o", mips_pkg::EC_NONE, ex_exc_code_o);
		check_op("ex_aluop_o", mips_pkg::SLL, ex_aluop_o);
		finish_test("reset", errs_before);

		row  = 0;
		done = 1'b0;
		while (!done) begin
			base = row * COLS;
			if (row >= MAX_ROWS || vec[base] === 32'hffffffff) begin
				done = 1'b1;
			end else begin
				errs_before = errors;
				drive_row(base);
				#1;
				check_word("stall_o", vec[base+5], 32'(stall_o));
				// Register file reads rs and rt
				check_word("reg1_addr_o", 32'(vec[base+1][25:21]), 32'(reg1_addr_o));
				check_word("reg2_addr_o", 32'(vec[base+1][20:16]), 32'(reg2_addr_o));
				@(negedge clk);
				check_row(base);
				finish_test($sformatf("pc %h inst %h", vec[base], vec[base+1]), errs_before);
				row++;
			end
		end

		// Idle the front end and let the pipeline drain
		inst_i         = '0;
		mem_stallreq_i = 1'b0;
		flush_i        = 1'b0;
		wait_stall_clear("drain");

		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
